// ==== icache_top.f ====
logic/icache_pkg.sv
logic/icache_way_ram.sv
logic/icache_tzc_idx.sv
logic/icache_lookup.sv
logic/icache_checker.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/icache_clk_gen.sv
testbench/icache_tb.sv

// ==== testbench/icache_tb.sv ====
// icache testbench
// drives fetch requests into the two-stage cache, models the fill memory
// and a valid/round-robin scoreboard, and checks with concurrent assertions
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic [ADDR_WIDTH-1:0]  req_addr;
    logic                   ready;
    logic                   resp_valid;
    logic [FETCH_WIDTH-1:0] resp_data;
    logic [ADDR_WIDTH-1:0]  resp_addr;
    logic                   flush;
    logic                   fill_req;
    logic [ADDR_WIDTH-1:0]  fill_addr;
    logic                   fill_valid;
    line_t                  fill_data;

    // scoreboard of valid lines and victim pointers
    logic [ICACHE_N_WAY-1:0]         model_valid [ICACHE_N_SETS];
    tag_t                            model_tag [ICACHE_N_SETS][ICACHE_N_WAY];
    logic [ICACHE_WAY_IDX_WIDTH-1:0] model_ptr [ICACHE_N_SETS];

    // expected responses in request order
    logic [ADDR_WIDTH-1:0] exp_addr [256];
    logic                  exp_miss [256];
    logic [7:0]            wr_ptr = '0;
    logic [7:0]            rd_ptr;
    logic                  pred_miss = 1'b0;
    logic                  miss_taken_q;
    logic                  fill_seen_q;

    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int unsigned cycles = 0;
    // 74 requests over six tests, 16 cycles each at worst
    int unsigned cycle_limit = 74 * 16 + 200;

    icache_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    icache_top u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .ready_o      (ready),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data),
        .resp_addr_o  (resp_addr),
        .flush_i      (flush),
        .fill_req_o   (fill_req),
        .fill_addr_o  (fill_addr),
        .fill_valid_i (fill_valid),
        .fill_data_i  (fill_data)
    );

    // memory content: each word is its own aligned address xor a fixed mask
    function automatic logic [FETCH_WIDTH-1:0] rule_word(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[ADDR_WIDTH-1:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic line_t rule_line(input logic [ADDR_WIDTH-1:0] line_addr);
        line_t line;
        for (int k = 0; k < WAY_WIDTH / FETCH_WIDTH; k++) begin
            line[k*FETCH_WIDTH +: FETCH_WIDTH] = (line_addr + 4 * k) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    // response pointer and fill bookkeeping
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr       <= '0;
            fill_seen_q  <= 1'b0;
            miss_taken_q <= 1'b0;
        end else begin
            if (resp_valid) begin
                rd_ptr <= rd_ptr + 8'd1;
            end
            if (resp_valid) begin
                fill_seen_q <= 1'b0;
            end else if (fill_req) begin
                fill_seen_q <= 1'b1;
            end
            miss_taken_q <= req_valid && ready && pred_miss;
        end
    end

    a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> resp_data == rule_word(resp_addr))
        else begin
            $display("[ERROR] %0t resp_data_o got %h expected %h", $time,
                $sampled(resp_data), rule_word($sampled(resp_addr)));
            errors++;
        end

    a_resp_order: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> rd_ptr != wr_ptr && resp_addr == exp_addr[rd_ptr])
        else begin
            $display("[ERROR] %0t resp_addr_o got %h expected %h", $time,
                $sampled(resp_addr), exp_addr[$sampled(rd_ptr)]);
            errors++;
        end

    // a fill before a response exactly when the scoreboard saw a miss
    a_fill_predicted: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> fill_seen_q == exp_miss[rd_ptr])
        else begin
            $display("%0t response for %h disagrees with the predicted hit/miss", $time,
                $sampled(resp_addr));
            errors++;
        end

    a_fill_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(fill_req) |-> fill_addr == {exp_addr[rd_ptr][ADDR_WIDTH-1:4], 4'h0})
        else begin
            $display("[ERROR] %0t fill_addr_o got %h expected %h", $time,
                $sampled(fill_addr), {exp_addr[$sampled(rd_ptr)][ADDR_WIDTH-1:4], 4'h0});
            errors++;
        end

    // fetch side must see back-pressure for the whole fill
    a_ready_stall: assert property (@(posedge clk) disable iff (!rst_n)
        fill_req |-> !ready)
        else begin
            $display("%0t ready_o high while a line fill is pending", $time);
            errors++;
        end

    // a hit not queued behind a miss comes back two edges later
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && ready && !pred_miss && !miss_taken_q |-> ##3 resp_valid)
        else begin
            $display("%0t hit response missing two cycles after its request", $time);
            errors++;
        end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d responses outstanding",
                cycles, wr_ptr - rd_ptr);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // fill memory, random 1 to 8 cycle latency
    task automatic serve_fills();
        int unsigned delay;
        forever begin
            @(negedge clk);
            if (fill_req) begin
                delay = ($urandom % 8) + 1;
                repeat (delay - 1) @(negedge clk);
                fill_valid = 1'b1;
                fill_data  = rule_line(fill_addr);
                @(negedge clk);
                fill_valid = 1'b0;
            end
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < ICACHE_N_SETS; s++) begin
            model_valid[s] = '0;
            model_ptr[s]   = '0;
        end
    endtask

    // hit or miss in request order, a miss fills the round-robin victim
    task automatic predict(input logic [ADDR_WIDTH-1:0] addr, output logic miss);
        int   idx;
        tag_t tag;
        idx  = addr[ICACHE_OFFSET_WIDTH +: ICACHE_INDEX_WIDTH];
        tag  = addr[ADDR_WIDTH-1 -: ICACHE_TAG_WIDTH];
        miss = 1'b1;
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                miss = 1'b0;
            end
        end
        if (miss) begin
            model_valid[idx][model_ptr[idx]] = 1'b1;
            model_tag[idx][model_ptr[idx]]   = tag;
            model_ptr[idx]                   = model_ptr[idx] + 1'b1;
        end
        exp_addr[wr_ptr] = addr;
        exp_miss[wr_ptr] = miss;
        wr_ptr           = wr_ptr + 8'd1;
    endtask

    // called on a falling edge, returns on the falling edge after the take
    task automatic issue_req(input logic [ADDR_WIDTH-1:0] addr);
        logic miss;
        while (!ready) begin
            req_valid = 1'b0;
            pred_miss = 1'b0;
            @(negedge clk);
        end
        predict(addr, miss);
        req_valid = 1'b1;
        req_addr  = addr;
        pred_miss = miss;
        @(negedge clk);
    endtask

    task automatic idle_req();
        req_valid = 1'b0;
        pred_miss = 1'b0;
        @(negedge clk);
    endtask

    task automatic drain();
        req_valid = 1'b0;
        pred_miss = 1'b0;
        while (rd_ptr != wr_ptr) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic flush_cache();
        drain();
        flush = 1'b1;
        clear_model();
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        drain();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        void'($urandom(32'h36f9));
        req_valid  = 1'b0;
        req_addr   = '0;
        flush      = 1'b0;
        fill_valid = 1'b0;
        fill_data  = '0;
        clear_model();
        fork
            serve_fills();
        join_none
        wait (rst_n);
        @(negedge clk);

        // cold miss, then every word of the same line
        issue_req(32'h0000_1000);
        for (int i = 0; i < 4; i++) begin
            issue_req(32'h0000_1000 + 4 * i);
        end
        end_test("cold miss and line hits");

        // warm a second line, then one hit per cycle
        issue_req(32'h0000_2040);
        drain();
        for (int i = 0; i < 4; i++) begin
            issue_req(32'h0000_1000 + 4 * i);
            issue_req(32'h0000_2040 + 4 * i);
        end
        end_test("back-to-back hits");

        // younger request held behind a miss
        issue_req(32'h0000_3080);
        issue_req(32'h0000_1004);
        drain();
        issue_req(32'h0000_40c0);
        issue_req(32'h0000_40c8);
        drain();
        issue_req(32'h0000_5100);
        issue_req(32'h0000_6140);
        end_test("request behind a miss");

        // set 9 overflows, way 0 goes first
        issue_req(32'h0001_0090);
        issue_req(32'h0002_0090);
        issue_req(32'h0003_0094);
        issue_req(32'h0004_0098);
        issue_req(32'h0005_009c);
        issue_req(32'h0001_0090);
        end_test("round-robin eviction");

        // everything misses once after a flush
        flush_cache();
        for (int r = 0; r < 2; r++) begin
            issue_req(32'h0000_1000);
            issue_req(32'h0000_2044);
            issue_req(32'h0000_3088);
            issue_req(32'h0001_0090);
        end
        end_test("flush and refetch");

        // six tags over four sets, random gaps
        for (int i = 0; i < 40; i++) begin
            addr = (($urandom % 6) << 8) | (($urandom % 4) << 4) | (($urandom % 4) << 2);
            issue_req(addr);
            if (($urandom % 4) == 0) begin
                idle_req();
            end
        end
        end_test("random footprint");

        $display("%0d tests run, %0d passed, %0d failed, %0d assertion errors",
            tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/icache_clk_gen.sv ====
// icache testbench clock and reset
// 100 ns clock, reset held low for the first five cycles
`timescale 1ns/1ps

module icache_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // release on a falling edge, in step with the stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== logic/icache_top.sv ====
// icache top level
// two-stage read-only instruction cache
// lookup, tag check, miss controller and the tag and line arrays
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // fetch
    input  logic                   req_valid_i,
    input  logic [ADDR_WIDTH-1:0]  req_addr_i,
    output logic                   ready_o,
    output logic                   resp_valid_o,
    output logic [FETCH_WIDTH-1:0] resp_data_o,
    output logic [ADDR_WIDTH-1:0]  resp_addr_o,
    input  logic                   flush_i,
    // line fill
    output logic                   fill_req_o,
    output logic [ADDR_WIDTH-1:0]  fill_addr_o,
    input  logic                   fill_valid_i,
    input  line_t                  fill_data_i
);

    logic                            rd_en;
    logic [ICACHE_INDEX_WIDTH-1:0]   rd_idx;
    logic                            s2_valid;
    logic [ADDR_WIDTH-1:0]           s2_addr;
    logic                            miss;
    logic                            fill_done;
    logic [ICACHE_N_WAY-1:0]         valid_bits;
    tag_t  [ICACHE_N_WAY-1:0]        rd_tags;
    line_t [ICACHE_N_WAY-1:0]        rd_lines;
    logic [ICACHE_N_WAY-1:0]         cline_hit;
    logic [FETCH_WIDTH-1:0]          hit_data;
    logic                            wr_en;
    logic [ICACHE_WAY_IDX_WIDTH-1:0] wr_way;
    logic [ICACHE_INDEX_WIDTH-1:0]   wr_idx;
    tag_t                            wr_tag;
    line_t                           wr_line;
    logic [ICACHE_N_WAY-1:0]         way_wr_en;

    // stage one
    icache_lookup u_lookup (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_addr_i  (req_addr_i),
        .ready_o     (ready_o),
        .miss_i      (miss),
        .fill_done_i (fill_done),
        .rd_en_o     (rd_en),
        .rd_idx_o    (rd_idx),
        .s2_valid_o  (s2_valid),
        .s2_addr_o   (s2_addr)
    );

    // tag and line arrays, one pair per way
    for (genvar w = 0; w < ICACHE_N_WAY; w++) begin : g_way
        assign way_wr_en[w] = wr_en && (wr_way == ICACHE_WAY_IDX_WIDTH'(w));

        icache_way_ram #(.entry_t(tag_t)) u_tag_ram (
            .clk_i (clk_i), .rd_en_i (rd_en), .rd_idx_i (rd_idx), .rd_data_o (rd_tags[w]),
            .wr_en_i (way_wr_en[w]), .wr_idx_i (wr_idx), .wr_data_i (wr_tag)
        );

        icache_way_ram #(.entry_t(line_t)) u_data_ram (
            .clk_i (clk_i), .rd_en_i (rd_en), .rd_idx_i (rd_idx), .rd_data_o (rd_lines[w]),
            .wr_en_i (way_wr_en[w]), .wr_idx_i (wr_idx), .wr_data_i (wr_line)
        );
    end

    // stage two
    icache_checker u_checker (
        .s2_addr_i        (s2_addr),
        .way_valid_bits_i (valid_bits),
        .read_tags_i      (rd_tags),
        .data_rd_i        (rd_lines),
        .cline_hit_o      (cline_hit),
        .data_o           (hit_data)
    );

    // miss handling and responses
    icache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .s2_valid_i   (s2_valid),
        .s2_addr_i    (s2_addr),
        .cline_hit_i  (cline_hit),
        .hit_data_i   (hit_data),
        .valid_bits_o (valid_bits),
        .miss_o       (miss),
        .fill_done_o  (fill_done),
        .fill_req_o   (fill_req_o),
        .fill_addr_o  (fill_addr_o),
        .fill_valid_i (fill_valid_i),
        .fill_data_i  (fill_data_i),
        .wr_en_o      (wr_en),
        .wr_way_o     (wr_way),
        .wr_idx_o     (wr_idx),
        .wr_tag_o     (wr_tag),
        .wr_line_o    (wr_line),
        .resp_valid_o (resp_valid_o),
        .resp_data_o  (resp_data_o),
        .resp_addr_o  (resp_addr_o)
    );

endmodule

// ==== logic/icache_ctrl.sv ====
// icache miss controller
// owns the valid bits and the per-set round-robin victim pointers
// runs one line fill at a time and produces every response
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    // stage two
    input  logic                            s2_valid_i,
    input  logic [ADDR_WIDTH-1:0]           s2_addr_i,
    input  logic [ICACHE_N_WAY-1:0]         cline_hit_i,
    input  logic [FETCH_WIDTH-1:0]          hit_data_i,
    output logic [ICACHE_N_WAY-1:0]         valid_bits_o,
    // to lookup
    output logic                            miss_o,
    output logic                            fill_done_o,
    // memory side
    output logic                            fill_req_o,
    output logic [ADDR_WIDTH-1:0]           fill_addr_o,
    input  logic                            fill_valid_i,
    input  line_t                           fill_data_i,
    // array write
    output logic                            wr_en_o,
    output logic [ICACHE_WAY_IDX_WIDTH-1:0] wr_way_o,
    output logic [ICACHE_INDEX_WIDTH-1:0]   wr_idx_o,
    output tag_t                            wr_tag_o,
    output line_t                           wr_line_o,
    // response to fetch
    output logic                            resp_valid_o,
    output logic [FETCH_WIDTH-1:0]          resp_data_o,
    output logic [ADDR_WIDTH-1:0]           resp_addr_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_RESP
    } state_e;

    state_e                                         state_q;
    logic [ICACHE_N_SETS-1:0][ICACHE_N_WAY-1:0]     valid_q;
    logic [ICACHE_WAY_IDX_WIDTH-1:0]                victim_q [ICACHE_N_SETS];
    logic [ICACHE_INDEX_WIDTH-1:0]                  s2_idx;
    logic                                           s2_live;
    logic                                           s2_hit;
    logic                                           s2_miss;
    logic                                           flush_take;
    logic [FETCH_WIDTH-1:0]                         fill_word;

    assign s2_idx = s2_addr_i[ICACHE_OFFSET_WIDTH +: ICACHE_INDEX_WIDTH];

    // stage two only counts while no fill is in progress
    assign s2_live = s2_valid_i && (state_q == S_IDLE);
    assign s2_hit  = s2_live && (|cline_hit_i);
    assign s2_miss = s2_live && !(|cline_hit_i);

    // valid bits of the indexed set, zero when stage two is idle or frozen
    assign valid_bits_o = s2_live ? valid_q[s2_idx] : '0;

    // stall covers the detect cycle and the whole fill wait
    assign miss_o      = s2_miss || (state_q == S_FILL);
    assign fill_done_o = (state_q == S_RESP);
    assign fill_req_o  = (state_q == S_FILL);

    // stage two is frozen during the fill, so its address stays put
    assign fill_addr_o = {s2_addr_i[ADDR_WIDTH-1:ICACHE_OFFSET_WIDTH], {ICACHE_OFFSET_WIDTH{1'b0}}};

    // line lands in the victim way at the edge after fill_valid_i
    assign wr_en_o   = (state_q == S_FILL) && fill_valid_i;
    assign wr_way_o  = victim_q[s2_idx];
    assign wr_idx_o  = s2_idx;
    assign wr_tag_o  = s2_addr_i[ADDR_WIDTH-1 -: ICACHE_TAG_WIDTH];
    assign wr_line_o = fill_data_i;

    // requested word straight from memory
    assign fill_word = fill_data_i[s2_addr_i[ICACHE_OFFSET_WIDTH-1:2]*FETCH_WIDTH +: FETCH_WIDTH];

    // flush only between requests that need no fill
    assign flush_take = flush_i && (state_q == S_IDLE) && !s2_miss;

    // miss sequence, valid bits, victim pointers
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= S_IDLE;
            resp_valid_o <= 1'b0;
            valid_q      <= '0;
            victim_q     <= '{default: '0};
        end else begin
            resp_valid_o <= s2_hit || wr_en_o;
            case (state_q)
                S_IDLE: if (s2_miss) state_q <= S_FILL;
                S_FILL: if (fill_valid_i) state_q <= S_RESP;
                default: state_q <= S_IDLE;
            endcase
            if (flush_take) begin
                valid_q  <= '0;
                victim_q <= '{default: '0};
            end else if (wr_en_o) begin
                valid_q[s2_idx][wr_way_o] <= 1'b1;
                victim_q[s2_idx]          <= victim_q[s2_idx] + ICACHE_WAY_IDX_WIDTH'(1);
            end
        end
    end

    // response payload
    always_ff @(posedge clk_i) begin
        if (s2_hit || wr_en_o) begin
            resp_data_o <= s2_hit ? hit_data_i : fill_word;
            resp_addr_o <= s2_addr_i;
        end
    end

    // memory must not answer a line nobody asked for
    a_fill_only_when_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_valid_i |-> fill_req_o)
        else $error("icache fill_valid_i without fill_req_o");

endmodule

// ==== logic/icache_checker.sv ====
// icache tag checker
// compares the read tags against the stage two address
// and picks the fetch word out of the hit line
`timescale 1ns/1ps

module icache_checker
    import icache_pkg::*;
(
    input  logic [ADDR_WIDTH-1:0]         s2_addr_i,
    input  logic [ICACHE_N_WAY-1:0]       way_valid_bits_i,
    input  tag_t [ICACHE_N_WAY-1:0]       read_tags_i,
    // lines read from every way
    input  line_t [ICACHE_N_WAY-1:0]      data_rd_i,
    output logic [ICACHE_N_WAY-1:0]       cline_hit_o,
    output logic [FETCH_WIDTH-1:0]        data_o
);

    logic [ICACHE_WAY_IDX_WIDTH-1:0]          idx;
    logic [ICACHE_N_WAY-1:0][FETCH_WIDTH-1:0] cline_sel;
    tag_t                                     s2_tag;
    logic [ICACHE_OFFSET_WIDTH-3:0]           word_sel;

    // tag is the top of the address
    assign s2_tag = s2_addr_i[ADDR_WIDTH-1 -: ICACHE_TAG_WIDTH];

    // word inside the line, byte bits dropped
    assign word_sel = s2_addr_i[ICACHE_OFFSET_WIDTH-1:2];

    for (genvar i = 0; i < ICACHE_N_WAY; i++) begin : g_tag_cmp
        // match only counts on a valid way
        assign cline_hit_o[i] = (read_tags_i[i] == s2_tag) && way_valid_bits_i[i];
        assign cline_sel[i]   = data_rd_i[i][word_sel*FETCH_WIDTH +: FETCH_WIDTH];
    end

    // hit way number
    icache_tzc_idx u_tzc_idx (
        .in_i  (cline_hit_o),
        .way_o (idx)
    );

    // word of the hit way, don't care on a miss
    assign data_o = cline_sel[idx];

endmodule

// ==== logic/icache_lookup.sv ====
// icache lookup stage
// takes fetch requests, drives the array read and the stage two registers
// freezes while a miss is outstanding, then replays the held read
`timescale 1ns/1ps

module icache_lookup
    import icache_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // fetch side
    input  logic                          req_valid_i,
    input  logic [ADDR_WIDTH-1:0]         req_addr_i,
    output logic                          ready_o,
    // from the miss controller
    input  logic                          miss_i,
    input  logic                          fill_done_i,
    // array read
    output logic                          rd_en_o,
    output logic [ICACHE_INDEX_WIDTH-1:0] rd_idx_o,
    // stage two
    output logic                          s2_valid_o,
    output logic [ADDR_WIDTH-1:0]         s2_addr_o
);

    logic                  s1_valid_q;
    logic [ADDR_WIDTH-1:0] s1_addr_q;
    logic                  req_take;

    // no new request while stalled or in the replay cycle
    assign ready_o  = !miss_i && !fill_done_i;
    assign req_take = req_valid_i && ready_o;

    // read the set of the stage one request as it moves on
    // in the replay cycle this rereads the freshly filled array
    assign rd_en_o  = s1_valid_q && !miss_i;
    assign rd_idx_o = s1_addr_q[ICACHE_OFFSET_WIDTH +: ICACHE_INDEX_WIDTH];

    // valid flags
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_o <= 1'b0;
        end else if (!miss_i) begin
            s1_valid_q <= req_take;
            s2_valid_o <= s1_valid_q;
        end
    end

    // addresses
    always_ff @(posedge clk_i) begin
        if (!miss_i) begin
            s2_addr_o <= s1_addr_q;
        end
        if (req_take) begin
            s1_addr_q <= req_addr_i;
        end
    end

    // held request must survive a stall untouched
    a_no_take_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !ready_o |=> $stable(s1_addr_q) && !$rose(s1_valid_q))
        else $error("icache request taken while ready_o low");

endmodule

// ==== logic/icache_tzc_idx.sv ====
// icache trailing zero index
// turns the one-hot hit vector into a way number
`timescale 1ns/1ps

module icache_tzc_idx
    import icache_pkg::*;
(
    input  logic [ICACHE_N_WAY-1:0]         in_i,
    output logic [ICACHE_WAY_IDX_WIDTH-1:0] way_o
);

    // scan from the top so the lowest set bit wins
    // zero input leaves way 0
    always_comb begin
        way_o = '0;
        for (int i = ICACHE_N_WAY - 1; i >= 0; i--) begin
            if (in_i[i]) begin
                way_o = ICACHE_WAY_IDX_WIDTH'(i);
            end
        end
    end

    // two ways with the same valid tag means the fill logic broke
    always_comb begin
        if (!$isunknown(in_i)) begin
            assert final ($onehot0(in_i))
                else $error("icache hit vector not one-hot: %b", in_i);
        end
    end

endmodule

// ==== logic/icache_way_ram.sv ====
// icache way array
// one way of the cache, one entry per set
// registered read, write takes effect at the clock edge
`timescale 1ns/1ps

module icache_way_ram
    import icache_pkg::*;
#(
    parameter type entry_t = tag_t
) (
    input  logic                          clk_i,
    // read side, data valid the cycle after rd_en_i
    input  logic                          rd_en_i,
    input  logic [ICACHE_INDEX_WIDTH-1:0] rd_idx_i,
    output entry_t                        rd_data_o,
    // write side from the miss controller
    input  logic                          wr_en_i,
    input  logic [ICACHE_INDEX_WIDTH-1:0] wr_idx_i,
    input  entry_t                        wr_data_i
);

    // storage, one entry per set
    entry_t mem_q [ICACHE_N_SETS];

    // write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

    // read port
    // same-index write in the same cycle returns the old entry
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_idx_i];
        end
    end

    // output holds when rd_en_i is low
    // so stage two keeps its set while stalled

endmodule

// ==== logic/icache_pkg.sv ====
// icache package
// geometry of the read-only instruction cache and the payload types
// shared by the way arrays, the tag checker and the miss controller
package icache_pkg;

    // associativity and set count
    localparam int ICACHE_N_WAY = 4;
    localparam int ICACHE_N_SETS = 16;

    // bits needed to name one way
    localparam int ICACHE_WAY_IDX_WIDTH = $clog2(ICACHE_N_WAY);

    // set index sits right above the line offset
    localparam int ICACHE_INDEX_WIDTH = 4;

    // 16-byte lines, so 4 offset bits
    localparam int ICACHE_OFFSET_WIDTH = 4;

    // physical byte address from fetch
    localparam int ADDR_WIDTH = 32;

    // everything above index and offset
    localparam int ICACHE_TAG_WIDTH = ADDR_WIDTH - ICACHE_INDEX_WIDTH - ICACHE_OFFSET_WIDTH;

    // one full line as returned by memory
    localparam int WAY_WIDTH = 128;

    // one instruction word
    localparam int FETCH_WIDTH = 32;

    // stored tag of one way
    typedef logic [ICACHE_TAG_WIDTH-1:0] tag_t;

    // one cache line, word 0 in the low bits
    typedef logic [WAY_WIDTH-1:0] line_t;

endpackage
